//--- arcade_pkg.sv
/*
 * shared types and constants for the arcade frame
 * bridge address map, game ids and board models
 * data table and raster timing constants, key bit positions
 */
package arcade_pkg;

    ////////////////////////////////////////
    // types

    typedef logic [31:0] bridge_addr_t;
    typedef logic [31:0] bridge_data_t;
    typedef logic [2:0]  game_id_t;
    typedef logic [2:0]  board_model_t;
    typedef logic [15:0] key_map_t;
    typedef logic [8:0]  pos_t;
    // red [11:8], green [7:4], blue [3:0]
    typedef logic [11:0] rgb12_t;
    typedef logic [23:0] rgb24_t;
    typedef logic [9:0]  dt_addr_t;

    ////////////////////////////////////////
    // bridge address map

    localparam bridge_addr_t GAME_ID_ADDR       = 32'h8000_0000;
    localparam bridge_addr_t GAME_SETTINGS_ADDR = 32'h9000_0000;

    // game ids and board models
    localparam game_id_t     GAME_ID_SUPERPAC = 3'd5;
    localparam game_id_t     GAME_ID_GROBDA   = 3'd6;
    localparam board_model_t BOARD_DRUAGA     = 3'd0;
    localparam board_model_t BOARD_SUPERPAC   = 3'd5;
    localparam board_model_t BOARD_GROBDA     = 3'd6;

    // data table, slot index 1 size word
    localparam bridge_data_t SAVE_SIZE_BYTES   = 32'd65536;
    localparam dt_addr_t     SAVE_SLOT_DT_ADDR = 10'd3;
    localparam logic [2:0]   DT_DIV_THRESHOLD  = 3'd4;

    ////////////////////////////////////////
    // raster timing

    localparam pos_t H_BLANK_END   = 9'd1;
    localparam pos_t H_BLANK_START = 9'd290;
    localparam pos_t H_SYNC_START  = 9'd311;
    localparam pos_t H_SYNC_END    = 9'd342;
    localparam pos_t H_RESUME      = 9'd471;
    localparam pos_t H_LAST        = 9'd511;
    localparam pos_t V_BLANK_START = 9'd223;
    localparam pos_t V_SYNC_START  = 9'd234;
    localparam pos_t V_SYNC_END    = 9'd241;
    localparam pos_t V_RESUME      = 9'd491;
    localparam pos_t V_LAST        = 9'd511;

    // clocks per line and lines per frame after the jumps
    localparam int LINE_CLOCKS = 384;
    localparam int FRAME_LINES = 263;

    // controller key bitmap positions
    localparam int KEY_UP     = 0;
    localparam int KEY_DOWN   = 1;
    localparam int KEY_LEFT   = 2;
    localparam int KEY_RIGHT  = 3;
    localparam int KEY_A      = 4;
    localparam int KEY_B      = 5;
    localparam int KEY_L1     = 8;
    localparam int KEY_SELECT = 14;
    localparam int KEY_START  = 15;

endpackage

//--- video_if.sv
/*
 * raster video bundle
 * blanking, sync and 12-bit colour from timing to output stage
 */
`timescale 1ns/1ps

interface video_if;
    import arcade_pkg::*;

    // blanking, active high
    logic   hblank;
    logic   vblank;
    // sync levels as the timing generator makes them
    logic   hsync;
    logic   vsync;
    // pixel colour, already zero during blanking
    rgb12_t colour;

    // driver side
    modport timing (output hblank, vblank, hsync, vsync, colour);

    // consumer side
    modport sink (input hblank, vblank, hsync, vsync, colour);

endinterface

//--- board_config.sv
/*
 * bridge configuration registers (game id, game settings)
 * game id to board model decode
 * rom download flag and core reset
 */
`timescale 1ns/1ps

module board_config (
    input  logic                    clk_74a,
    input  logic                    pll_core_locked,
    input  logic                    reset_n,
    input  arcade_pkg::bridge_addr_t bridge_addr,
    input  logic                    bridge_wr,
    input  arcade_pkg::bridge_data_t bridge_wr_data,
    input  logic                    dataslot_requestwrite,
    input  logic                    dataslot_allcomplete,
    output arcade_pkg::board_model_t board_model,
    output arcade_pkg::bridge_data_t game_settings,
    output logic                    core_reset
);
    import arcade_pkg::*;

    game_id_t game_id;
    logic     download;

    ////////////////////////////////////////
    // bridge writes
    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            game_id       <= '0;
            game_settings <= '0;
        end else if (bridge_wr) begin
            // exact word match, other addresses ignored
            if (bridge_addr == GAME_ID_ADDR) begin
                game_id <= bridge_wr_data[2:0];
            end
            if (bridge_addr == GAME_SETTINGS_ADDR) begin
                game_settings <= bridge_wr_data;
            end
        end
    end

    // board model one cycle behind game id
    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            board_model <= BOARD_DRUAGA;
        end else if (game_id == GAME_ID_GROBDA) begin
            board_model <= BOARD_GROBDA;
        end else if (game_id == GAME_ID_SUPERPAC) begin
            board_model <= BOARD_SUPERPAC;
        end else begin
            // druaga, mappy, digdug2, motos share one board
            board_model <= BOARD_DRUAGA;
        end
    end

    ////////////////////////////////////////
    // rom download window
    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            download <= 1'b0;
        end else if (dataslot_requestwrite) begin
            // start of load wins over a coincident complete
            download <= 1'b1;
        end else if (dataslot_allcomplete) begin
            download <= 1'b0;
        end
    end

    // hold the core in reset while loading
    assign core_reset = ~reset_n | download;

endmodule

//--- datatable_writer.sv
/*
 * data table sequencer
 * writes the save slot size word in the upper part of an 8-count cycle
 */
`timescale 1ns/1ps

module datatable_writer (
    input  logic                    clk_74a,
    input  logic                    pll_core_locked,
    output arcade_pkg::dt_addr_t     datatable_addr,
    output logic                    datatable_wren,
    output arcade_pkg::bridge_data_t datatable_data
);
    import arcade_pkg::*;

    // free-running divider, wraps every 8 cycles
    logic [2:0] dt_div;

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            dt_div         <= '0;
            datatable_addr <= '0;
            datatable_data <= '0;
            datatable_wren <= 1'b0;
        end else begin
            if (dt_div > DT_DIV_THRESHOLD) begin
                // counts 5 to 7, announce the save area size
                datatable_wren <= 1'b1;
                datatable_addr <= SAVE_SLOT_DT_ADDR;
                datatable_data <= SAVE_SIZE_BYTES;
            end else begin
                // idle on the slot 0 size word
                datatable_wren <= 1'b0;
                datatable_addr <= 10'd1;
            end
            dt_div <= dt_div + 3'd1;
        end
    end

endmodule

//--- player_inputs.sv
/*
 * controller key synchroniser, three flops per pad
 * mapping to the arcade player input groups
 */
`timescale 1ns/1ps

module player_inputs (
    input  logic                clk_74a,
    input  logic                pll_core_locked,
    input  arcade_pkg::key_map_t cont1_key,
    input  arcade_pkg::key_map_t cont2_key,
    output logic [5:0]          inp0,
    output logic [5:0]          inp1,
    output logic [2:0]          inp2
);
    import arcade_pkg::*;

    // sync chains, index 2 is the settled copy
    key_map_t pad1_s [0:2];
    key_map_t pad2_s [0:2];
    key_map_t pad1;
    key_map_t pad2;

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            pad1_s[0] <= '0;
            pad1_s[1] <= '0;
            pad1_s[2] <= '0;
            pad2_s[0] <= '0;
            pad2_s[1] <= '0;
            pad2_s[2] <= '0;
        end else begin
            pad1_s[0] <= cont1_key;
            pad1_s[1] <= pad1_s[0];
            pad1_s[2] <= pad1_s[1];
            pad2_s[0] <= cont2_key;
            pad2_s[1] <= pad2_s[0];
            pad2_s[2] <= pad2_s[1];
        end
    end

    assign pad1 = pad1_s[2];
    assign pad2 = pad2_s[2];

    ////////////////////////////////////////
    // arcade input groups, active high

    // player 1 {b2, b1, left, down, right, up}
    assign inp0 = {pad1[KEY_B], pad1[KEY_A], pad1[KEY_LEFT],
                   pad1[KEY_DOWN], pad1[KEY_RIGHT], pad1[KEY_UP]};

    // player 2, same order
    assign inp1 = {pad2[KEY_B], pad2[KEY_A], pad2[KEY_LEFT],
                   pad2[KEY_DOWN], pad2[KEY_RIGHT], pad2[KEY_UP]};

    // {coin, start2, start1}
    // either select inserts a coin
    assign inp2 = {pad1[KEY_SELECT] | pad2[KEY_SELECT],
                   pad2[KEY_START],
                   pad1[KEY_START]};

endmodule

//--- raster_timing.sv
/*
 * raster timing generator, one step per clock
 * blanking and sync levels, pixel byte to 12-bit colour
 */
`timescale 1ns/1ps

module raster_timing (
    input  logic            clk_74a,
    input  logic            pll_core_locked,
    input  logic [7:0]      core_pix,
    output arcade_pkg::pos_t h_pos,
    output arcade_pkg::pos_t v_pos,
    video_if.timing         vid
);
    import arcade_pkg::*;

    pos_t   h_cnt;
    pos_t   v_cnt;
    rgb12_t pix_rgb;

    // the core reads the counters directly
    assign h_pos = h_cnt;
    assign v_pos = v_cnt;

    // rrgggbbb to 4 bits per channel, low bits zero
    assign pix_rgb = {core_pix[7:6], 2'b00, core_pix[5:3], 1'b0, core_pix[2:0], 1'b0};

    ////////////////////////////////////////
    // counters, blank and sync
    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            h_cnt      <= '0;
            v_cnt      <= '0;
            vid.hblank <= 1'b1;
            vid.vblank <= 1'b1;
            vid.hsync  <= 1'b1;
            vid.vsync  <= 1'b1;
            vid.colour <= '0;
        end else begin
            case (h_cnt)
                H_BLANK_END: begin
                    vid.hblank <= 1'b0;
                    h_cnt      <= h_cnt + 9'd1;
                end
                H_BLANK_START: begin
                    vid.hblank <= 1'b1;
                    h_cnt      <= h_cnt + 9'd1;
                end
                H_SYNC_START: begin
                    // sync is low during the pulse
                    vid.hsync <= 1'b0;
                    h_cnt     <= h_cnt + 9'd1;
                end
                H_SYNC_END: begin
                    vid.hsync <= 1'b1;
                    // skip the unused part of the line
                    h_cnt     <= H_RESUME;
                end
                H_LAST: begin
                    h_cnt <= '0;
                    // end of line, step the vertical counter
                    case (v_cnt)
                        V_BLANK_START: begin
                            vid.vblank <= 1'b1;
                            v_cnt      <= v_cnt + 9'd1;
                        end
                        V_SYNC_START: begin
                            vid.vsync <= 1'b0;
                            v_cnt     <= v_cnt + 9'd1;
                        end
                        V_SYNC_END: begin
                            vid.vsync <= 1'b1;
                            v_cnt     <= V_RESUME;
                        end
                        V_LAST: begin
                            // new frame, active area starts again
                            vid.vblank <= 1'b0;
                            v_cnt      <= '0;
                        end
                        default: v_cnt <= v_cnt + 9'd1;
                    endcase
                end
                default: h_cnt <= h_cnt + 9'd1;
            endcase
            // blank the colour on last cycle's blank state
            vid.colour <= (vid.hblank | vid.vblank) ? '0 : pix_rgb;
        end
    end

endmodule

//--- video_out.sv
/*
 * scaler video formatting
 * data enable, 4 to 8 bit colour, sync edge pulses
 */
`timescale 1ns/1ps

module video_out (
    input  logic              clk_74a,
    input  logic              pll_core_locked,
    video_if.sink             vid,
    output arcade_pkg::rgb24_t video_rgb,
    output logic              video_de,
    output logic              video_hs,
    output logic              video_vs
);

    // previous sync levels for edge detect
    logic hs_prev;
    logic vs_prev;

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            video_rgb <= '0;
            video_de  <= 1'b0;
            video_hs  <= 1'b0;
            video_vs  <= 1'b0;
            hs_prev   <= 1'b0;
            vs_prev   <= 1'b0;
        end else begin
            video_de <= 1'b0;
            if (!(vid.hblank || vid.vblank)) begin
                video_de <= 1'b1;
                // each nibble repeated to fill 8 bits
                video_rgb[23:16] <= {2{vid.colour[11:8]}};
                video_rgb[15:8]  <= {2{vid.colour[7:4]}};
                video_rgb[7:0]   <= {2{vid.colour[3:0]}};
            end
            // one cycle pulse on the rising sync edge
            video_hs <= ~hs_prev & vid.hsync;
            video_vs <= ~vs_prev & vid.vsync;
            hs_prev  <= vid.hsync;
            vs_prev  <= vid.vsync;
        end
    end

endmodule

//--- arcade_frame_top.sv
/*
 * arcade frame top level
 * config, data table, player inputs, raster timing and video out
 */
`timescale 1ns/1ps

module arcade_frame_top (
    input  logic                     clk_74a,
    input  logic                     pll_core_locked,
    input  logic                     reset_n,
    // bridge
    input  arcade_pkg::bridge_addr_t  bridge_addr,
    input  logic                     bridge_wr,
    input  arcade_pkg::bridge_data_t  bridge_wr_data,
    // dataslot events
    input  logic                     dataslot_requestwrite,
    input  logic                     dataslot_allcomplete,
    // controllers
    input  arcade_pkg::key_map_t      cont1_key,
    input  arcade_pkg::key_map_t      cont2_key,
    // pixel from the arcade core
    input  logic [7:0]               core_pix,
    // arcade core control
    output logic                     core_reset,
    output arcade_pkg::board_model_t  board_model,
    output arcade_pkg::bridge_data_t  game_settings,
    output logic [5:0]               inp0,
    output logic [5:0]               inp1,
    output logic [2:0]               inp2,
    output arcade_pkg::pos_t          h_pos,
    output arcade_pkg::pos_t          v_pos,
    // data table
    output arcade_pkg::dt_addr_t      datatable_addr,
    output logic                     datatable_wren,
    output arcade_pkg::bridge_data_t  datatable_data,
    // scaler video
    output arcade_pkg::rgb24_t        video_rgb,
    output logic                     video_de,
    output logic                     video_hs,
    output logic                     video_vs
);

    // timing to output stage
    video_if vid ();

    ////////////////////////////////////////
    // host side
    board_config u_board_config (
        .clk_74a               (clk_74a),
        .pll_core_locked       (pll_core_locked),
        .reset_n               (reset_n),
        .bridge_addr           (bridge_addr),
        .bridge_wr             (bridge_wr),
        .bridge_wr_data        (bridge_wr_data),
        .dataslot_requestwrite (dataslot_requestwrite),
        .dataslot_allcomplete  (dataslot_allcomplete),
        .board_model           (board_model),
        .game_settings         (game_settings),
        .core_reset            (core_reset)
    );

    datatable_writer u_datatable_writer (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .datatable_addr  (datatable_addr),
        .datatable_wren  (datatable_wren),
        .datatable_data  (datatable_data)
    );

    player_inputs u_player_inputs (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .cont1_key       (cont1_key),
        .cont2_key       (cont2_key),
        .inp0            (inp0),
        .inp1            (inp1),
        .inp2            (inp2)
    );

    ////////////////////////////////////////
    // video path
    raster_timing u_raster_timing (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .core_pix        (core_pix),
        .h_pos           (h_pos),
        .v_pos           (v_pos),
        .vid             (vid.timing)
    );

    video_out u_video_out (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .vid             (vid.sink),
        .video_rgb       (video_rgb),
        .video_de        (video_de),
        .video_hs        (video_hs),
        .video_vs        (video_vs)
    );

endmodule

//--- arcade_frame_assertions.sv
/*
 * concurrent checks bound to the arcade frame top level
 * board model, download reset, data table, player inputs, video output
 */
`timescale 1ns/1ps

module arcade_frame_assertions (
    input  logic                     clk_74a,
    input  logic                     pll_core_locked,
    input  logic                     reset_n,
    input  arcade_pkg::bridge_addr_t  bridge_addr,
    input  logic                     bridge_wr,
    input  arcade_pkg::bridge_data_t  bridge_wr_data,
    input  logic                     dataslot_requestwrite,
    input  logic                     dataslot_allcomplete,
    input  arcade_pkg::key_map_t      cont1_key,
    input  arcade_pkg::key_map_t      cont2_key,
    input  logic                     core_reset,
    input  arcade_pkg::board_model_t  board_model,
    input  arcade_pkg::bridge_data_t  game_settings,
    input  logic [5:0]               inp0,
    input  logic [5:0]               inp1,
    input  logic [2:0]               inp2,
    input  arcade_pkg::pos_t          h_pos,
    input  arcade_pkg::pos_t          v_pos,
    input  arcade_pkg::dt_addr_t      datatable_addr,
    input  logic                     datatable_wren,
    input  arcade_pkg::bridge_data_t  datatable_data,
    input  arcade_pkg::rgb24_t        video_rgb,
    input  logic                     video_de,
    input  logic                     video_hs,
    input  logic                     video_vs
);
    import arcade_pkg::*;

    // failed checks, read by the testbench at the end
    int fail_count = 0;
    // cycles since reset release
    int cycles;
    // clocks since the last hsync pulse, and pulses seen
    int hs_gap;
    int hs_count;

    // grobda and super pac-man have their own boards
    function automatic board_model_t board_for(input game_id_t id);
        if (id == 3'd6) return 3'd6;
        if (id == 3'd5) return 3'd5;
        return 3'd0;
    endfunction

    // {b, a, left, down, right, up}
    function automatic logic [5:0] pad_group(input key_map_t k);
        return {k[5], k[4], k[2], k[1], k[3], k[0]};
    endfunction

    // {coin, start2, start1}
    function automatic logic [2:0] system_group(input key_map_t k1, input key_map_t k2);
        return {k1[14] | k2[14], k2[15], k1[15]};
    endfunction

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            cycles   <= 0;
            hs_gap   <= 0;
            hs_count <= 0;
        end else begin
            cycles <= cycles + 1;
            if (video_hs) begin
                hs_gap   <= 1;
                hs_count <= hs_count + 1;
            end else begin
                hs_gap <= hs_gap + 1;
            end
        end
    end

    ////////////////////////////////////////
    // configuration and download

    a_board_model: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        $past(bridge_wr && bridge_addr == 32'h8000_0000, 2)
        |-> board_model == board_for($past(bridge_wr_data[2:0], 2)))
        else begin
            fail_count++;
            $error("board model does not follow the game id write");
        end

    a_settings: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        $past(bridge_wr && bridge_addr == 32'h9000_0000)
        |-> game_settings == $past(bridge_wr_data))
        else begin
            fail_count++;
            $error("game settings not updated one cycle after the write");
        end

    a_dl_rise: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        $past(dataslot_requestwrite) |-> core_reset)
        else begin
            fail_count++;
            $error("core reset low after a request write");
        end

    a_dl_fall: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        reset_n && $past(dataslot_allcomplete && !dataslot_requestwrite) |-> !core_reset)
        else begin
            fail_count++;
            $error("core reset still high after all complete");
        end

    // no event, no change
    a_dl_hold: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        reset_n && $past(reset_n) && !$past(dataslot_requestwrite || dataslot_allcomplete)
        |-> core_reset == $past(core_reset))
        else begin
            fail_count++;
            $error("core reset changed without a dataslot event");
        end

    a_reset_n: assert property (@(posedge clk_74a) !reset_n |-> core_reset)
        else begin
            fail_count++;
            $error("core reset low while reset_n is low");
        end

    ////////////////////////////////////////
    // data table and player inputs

    a_dt_fields: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        datatable_wren |-> datatable_addr == 10'd3 && datatable_data == 32'd65536)
        else begin
            fail_count++;
            $error("data table write with wrong address or data");
        end

    // three writes in any window of eight cycles
    a_dt_count: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        cycles >= 8 |-> $countones({datatable_wren, $past(datatable_wren, 1),
            $past(datatable_wren, 2), $past(datatable_wren, 3), $past(datatable_wren, 4),
            $past(datatable_wren, 5), $past(datatable_wren, 6),
            $past(datatable_wren, 7)}) == 3)
        else begin
            fail_count++;
            $error("data table write enable not high 3 of 8 cycles");
        end

    a_player: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        cycles >= 3 |-> inp0 == pad_group($past(cont1_key, 3))
            && inp1 == pad_group($past(cont2_key, 3))
            && inp2 == system_group($past(cont1_key, 3), $past(cont2_key, 3)))
        else begin
            fail_count++;
            $error("player inputs differ from the keys of 3 cycles earlier");
        end

    ////////////////////////////////////////
    // raster counters and video output

    // one step per clock, sync end jumps to resume, last wraps to zero
    a_h_pos: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        cycles >= 1 |-> h_pos == (($past(h_pos) == 9'd342) ? 9'd471 : $past(h_pos) + 9'd1))
        else begin
            fail_count++;
            $error("horizontal counter out of sequence");
        end

    a_de_nibbles: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        video_de |-> video_rgb[23:20] == video_rgb[19:16]
            && video_rgb[15:12] == video_rgb[11:8] && video_rgb[7:4] == video_rgb[3:0])
        else begin
            fail_count++;
            $error("colour channel nibbles differ while data enable is high");
        end

    a_de_vblank: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        v_pos >= 9'd224 |-> !video_de)
        else begin
            fail_count++;
            $error("data enable high in a vertical blank line");
        end

    a_hs_single: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        video_hs |-> !$past(video_hs))
        else begin
            fail_count++;
            $error("hsync pulse longer than one cycle");
        end

    a_vs_single: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        video_vs |-> !$past(video_vs))
        else begin
            fail_count++;
            $error("vsync pulse longer than one cycle");
        end

    // first pulse comes from the reset release, period checked from the second on
    a_hs_period: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        video_hs && hs_count >= 2 |-> hs_gap == 384)
        else begin
            fail_count++;
            $error("hsync pulses not one line apart");
        end

    a_hs_present: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        hs_count >= 2 |-> hs_gap <= 384)
        else begin
            fail_count++;
            $error("hsync pulse missing for more than one line");
        end

endmodule

bind arcade_frame_top arcade_frame_assertions checks (.*);

//--- tb_arcade_frame.sv
/*
 * testbench for the arcade frame top level
 * board model, download reset, data table, player input and video tests
 * one report line per test, closing counts, cycle timeout
 */
`timescale 1ns/1ps

module tb_arcade_frame;
    import arcade_pkg::*;

    // two frames plus margin for the short tests
    localparam int TIMEOUT_CYCLES = 2 * LINE_CLOCKS * FRAME_LINES + 2000;

    logic         clk_74a;
    logic         pll_core_locked;
    logic         reset_n;
    bridge_addr_t bridge_addr;
    logic         bridge_wr;
    bridge_data_t bridge_wr_data;
    logic         dataslot_requestwrite;
    logic         dataslot_allcomplete;
    key_map_t     cont1_key;
    key_map_t     cont2_key;
    logic [7:0]   core_pix;
    logic         core_reset;
    board_model_t board_model;
    bridge_data_t game_settings;
    logic [5:0]   inp0;
    logic [5:0]   inp1;
    logic [2:0]   inp2;
    pos_t         h_pos;
    pos_t         v_pos;
    dt_addr_t     datatable_addr;
    logic         datatable_wren;
    bridge_data_t datatable_data;
    rgb24_t       video_rgb;
    logic         video_de;
    logic         video_hs;
    logic         video_vs;

    int unsigned  cycle_count = 0;
    int           value_errors = 0;
    int           tests_run = 0;
    int           tests_failed = 0;
    int           errors_mark;
    int           fails_mark;
    int           idx;
    int           vs_count;
    string        test_name;
    bridge_data_t settings_word;

    // game ids written and the board each one selects
    game_id_t     test_ids    [3] = '{3'd6, 3'd5, 3'd2};
    board_model_t test_models [3] = '{3'd6, 3'd5, 3'd0};

    arcade_frame_top dut (.*);

    initial begin
        clk_74a = 1'b0;
        forever #20 clk_74a = ~clk_74a;
    end

    // hard stop if a wait never ends
    always @(posedge clk_74a) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////
    // helpers

    task automatic idle(input int n);
        repeat (n) @(negedge clk_74a);
    endtask

    task automatic bridge_write(input bridge_addr_t addr, input bridge_data_t data);
        @(negedge clk_74a);
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        @(negedge clk_74a);
        bridge_wr      = 1'b0;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error %s %s: expected %h, actual %h", test_name, name,
                     expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        errors_mark = value_errors;
        fails_mark  = dut.checks.fail_count;
    endtask

    // value mismatches plus assertion failures since start_test
    task automatic finish_test();
        int problems;
        problems = (value_errors - errors_mark) + (dut.checks.fail_count - fails_mark);
        tests_run++;
        if (problems == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d problems", test_name, problems);
        end
    endtask

    ////////////////////////////////////////
    // test sequence

    initial begin
        void'($urandom(32'h8fd5_6584));
        pll_core_locked       = 1'b0;
        reset_n               = 1'b0;
        bridge_addr           = '0;
        bridge_wr             = 1'b0;
        bridge_wr_data        = '0;
        dataslot_requestwrite = 1'b0;
        dataslot_allcomplete  = 1'b0;
        cont1_key             = '0;
        cont2_key             = '0;
        core_pix              = '0;
        repeat (3) @(negedge clk_74a);
        pll_core_locked = 1'b1;
        reset_n         = 1'b1;
        idle(4);

        // game id writes, model two cycles after the strobe
        start_test("board_model");
        for (idx = 0; idx < 3; idx++) begin
            bridge_write(GAME_ID_ADDR, {29'd0, test_ids[idx]});
            @(negedge clk_74a);
            check_value("board_model", 32'(test_models[idx]), 32'(board_model));
        end
        settings_word = $urandom;
        bridge_write(GAME_SETTINGS_ADDR, settings_word);
        check_value("game_settings", settings_word, game_settings);
        idle(2);
        finish_test();

        // load window, then a coincident pair, then reset_n alone
        start_test("download_reset");
        dataslot_requestwrite = 1'b1;
        idle(1);
        dataslot_requestwrite = 1'b0;
        idle(4);
        dataslot_allcomplete = 1'b1;
        idle(1);
        dataslot_allcomplete = 1'b0;
        idle(3);
        dataslot_requestwrite = 1'b1;
        dataslot_allcomplete  = 1'b1;
        idle(1);
        dataslot_requestwrite = 1'b0;
        dataslot_allcomplete  = 1'b0;
        idle(3);
        dataslot_allcomplete = 1'b1;
        idle(1);
        dataslot_allcomplete = 1'b0;
        idle(2);
        reset_n = 1'b0;
        idle(2);
        reset_n = 1'b1;
        idle(3);
        finish_test();

        // a few sequencer rounds after the first write
        start_test("data_table");
        while (!datatable_wren) @(negedge clk_74a);
        idle(16);
        finish_test();

        start_test("player_inputs");
        repeat (200) begin
            @(negedge clk_74a);
            cont1_key = 16'($urandom);
            cont2_key = 16'($urandom);
        end
        @(negedge clk_74a);
        cont1_key = '0;
        cont2_key = '0;
        idle(4);
        finish_test();

        // random pixels through a whole displayed frame and its vertical blank
        start_test("video_out");
        vs_count = 0;
        while (vs_count < 2) begin
            @(negedge clk_74a);
            core_pix = 8'($urandom);
            if (video_vs) begin
                vs_count++;
            end
        end
        while (v_pos != '0) begin
            @(negedge clk_74a);
            core_pix = 8'($urandom);
        end
        idle(4);
        finish_test();

        $display("tests run %0d, failed %0d, value errors %0d, assertion failures %0d",
                 tests_run, tests_failed, value_errors, dut.checks.fail_count);
        if (tests_failed == 0 && value_errors == 0 && dut.checks.fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- filelist.f
arcade_pkg.sv
video_if.sv
board_config.sv
datatable_writer.sv
player_inputs.sv
raster_timing.sv
video_out.sv
arcade_frame_top.sv
arcade_frame_assertions.sv
tb_arcade_frame.sv

//--- Makefile
SIM  = obj_dir/Vtb_arcade_frame
SRCS = arcade_pkg.sv video_if.sv board_config.sv datatable_writer.sv player_inputs.sv \
       raster_timing.sv video_out.sv arcade_frame_top.sv arcade_frame_assertions.sv \
       tb_arcade_frame.sv

.PHONY: all run clean

all: run

$(SIM): filelist.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_arcade_frame -f filelist.f

run: $(SIM)
	-./$(SIM) +verilator+error+limit+1000 > sim.log 2>&1
	@cat sim.log
	@grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
